// ==== logic/kerygma_pkg.sv ====
package kerygma_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int be_w   = 4;

    // address bits that steer a request to its target
    localparam int xif_bitsel = 31;
    localparam int sfr_bitsel = 20;

    // register block byte offsets
    localparam logic [sfr_bitsel-1:0] sfr_id_ofs     = 'h00;
    localparam logic [sfr_bitsel-1:0] sfr_ctrl_ofs   = 'h04;
    localparam logic [sfr_bitsel-1:0] sfr_irq_en_ofs = 'h08;
    localparam logic [sfr_bitsel-1:0] sfr_timer_ofs  = 'h0C;
    localparam logic [sfr_bitsel-1:0] sfr_sgi_ofs    = 'h10;

endpackage

// ==== logic/bus_arb_2m3s.sv ====
`timescale 1ns/1ps

module bus_arb_2m3s
(
    input  logic clk_i
    , input  logic rst_n_i

    , input  logic m0_req_i
    , input  logic m0_we_i
    , input  logic [kerygma_pkg::addr_w-1:0] m0_addr_i
    , input  logic [kerygma_pkg::be_w-1:0]   m0_be_i
    , input  logic [kerygma_pkg::data_w-1:0] m0_wdata_i
    , output logic m0_ack_o
    , output logic m0_resp_o
    , output logic [kerygma_pkg::data_w-1:0] m0_rdata_o

    , input  logic m1_req_i
    , input  logic m1_we_i
    , input  logic [kerygma_pkg::addr_w-1:0] m1_addr_i
    , input  logic [kerygma_pkg::be_w-1:0]   m1_be_i
    , input  logic [kerygma_pkg::data_w-1:0] m1_wdata_i
    , output logic m1_ack_o
    , output logic m1_resp_o
    , output logic [kerygma_pkg::data_w-1:0] m1_rdata_o

    , output logic s0_req_o
    , output logic s0_we_o
    , output logic [kerygma_pkg::addr_w-1:0] s0_addr_o
    , output logic [kerygma_pkg::be_w-1:0]   s0_be_o
    , output logic [kerygma_pkg::data_w-1:0] s0_wdata_o
    , input  logic s0_ack_i
    , input  logic s0_resp_i
    , input  logic [kerygma_pkg::data_w-1:0] s0_rdata_i

    , output logic s1_req_o
    , output logic s1_we_o
    , output logic [kerygma_pkg::addr_w-1:0] s1_addr_o
    , output logic [kerygma_pkg::be_w-1:0]   s1_be_o
    , output logic [kerygma_pkg::data_w-1:0] s1_wdata_o
    , input  logic s1_ack_i
    , input  logic s1_resp_i
    , input  logic [kerygma_pkg::data_w-1:0] s1_rdata_i

    , output logic s2_req_o
    , output logic s2_we_o
    , output logic [kerygma_pkg::addr_w-1:0] s2_addr_o
    , output logic [kerygma_pkg::be_w-1:0]   s2_be_o
    , output logic [kerygma_pkg::data_w-1:0] s2_wdata_o
    , input  logic s2_ack_i
    , input  logic s2_resp_i
    , input  logic [kerygma_pkg::data_w-1:0] s2_rdata_i
);

    import kerygma_pkg::*;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_gnt  = 2'd1;
    localparam logic [1:0] st_rd   = 2'd2;

    logic [1:0] state_q, gnt_s_q, pick_tgt, rd_pend_q;
    logic gnt_m_q, rr_q, pick;
    logic [addr_w-1:0] pick_addr, cmd_addr;
    logic cmd_req, cmd_we, route_req, gnt_ack, rsp_fwd, tgt_ack, tgt_resp;
    logic [be_w-1:0] cmd_be;
    logic [data_w-1:0] cmd_wdata, tgt_rdata;

    // round-robin only matters on a tie
    assign pick      = (m0_req_i && m1_req_i) ? rr_q : m1_req_i;
    assign pick_addr = pick ? m1_addr_i : m0_addr_i;
    assign pick_tgt  = pick_addr[xif_bitsel] ? 2'd2 : (pick_addr[sfr_bitsel] ? 2'd1 : 2'd0);

    assign {cmd_req, cmd_we, cmd_addr, cmd_be, cmd_wdata} = gnt_m_q
        ? {m1_req_i, m1_we_i, m1_addr_i, m1_be_i, m1_wdata_i}
        : {m0_req_i, m0_we_i, m0_addr_i, m0_be_i, m0_wdata_i};

    always_comb
    begin
        case (gnt_s_q)
            2'd1: {tgt_ack, tgt_resp, tgt_rdata} = {s1_ack_i, s1_resp_i, s1_rdata_i};
            2'd2: {tgt_ack, tgt_resp, tgt_rdata} = {s2_ack_i, s2_resp_i, s2_rdata_i};
            default: {tgt_ack, tgt_resp, tgt_rdata} = {s0_ack_i, s0_resp_i, s0_rdata_i};
        endcase
    end

    assign route_req = (state_q == st_gnt) && cmd_req;
    assign gnt_ack   = route_req && tgt_ack;
    assign rsp_fwd   = (state_q == st_rd) && tgt_resp;

    assign s0_req_o = route_req && (gnt_s_q == 2'd0);
    assign s1_req_o = route_req && (gnt_s_q == 2'd1);
    assign s2_req_o = route_req && (gnt_s_q == 2'd2);
    assign {s0_we_o, s0_addr_o, s0_be_o, s0_wdata_o} = {cmd_we, cmd_addr, cmd_be, cmd_wdata};
    assign {s1_we_o, s1_addr_o, s1_be_o, s1_wdata_o} = {cmd_we, cmd_addr, cmd_be, cmd_wdata};
    assign {s2_we_o, s2_addr_o, s2_be_o, s2_wdata_o} = {cmd_we, cmd_addr, cmd_be, cmd_wdata};

    assign m0_ack_o   = gnt_ack && !gnt_m_q;
    assign m1_ack_o   = gnt_ack && gnt_m_q;
    assign m0_resp_o  = rsp_fwd && !gnt_m_q;
    assign m1_resp_o  = rsp_fwd && gnt_m_q;
    assign m0_rdata_o = tgt_rdata;
    assign m1_rdata_o = tgt_rdata;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q <= st_idle;
            gnt_m_q <= 1'b0;
            gnt_s_q <= 2'd0;
            rr_q    <= 1'b0;
        end
        else
        begin
            case (state_q)
                st_idle:
                    if (m0_req_i || m1_req_i)
                    begin
                        state_q <= st_gnt;
                        gnt_m_q <= pick;
                        gnt_s_q <= pick_tgt;
                        rr_q    <= ~pick;
                    end
                st_gnt:
                    if (gnt_ack)
                        state_q <= cmd_we ? st_idle : st_rd;
                st_rd:
                    if (tgt_resp)
                        state_q <= st_idle;
                default:
                    state_q <= st_idle;
            endcase
        end
    end

    // reads accepted but not yet answered, per master
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            rd_pend_q <= 2'b00;
        else
            rd_pend_q <= (rd_pend_q & ~{m1_resp_o, m0_resp_o})
                       | {m1_ack_o && !m1_we_i, m0_ack_o && !m0_we_i};
    end

    a_m0_resp_pend: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m0_resp_o |-> rd_pend_q[0]);
    a_m1_resp_pend: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m1_resp_o |-> rd_pend_q[1]);

endmodule

// ==== logic/dmem_ram.sv ====
`timescale 1ns/1ps

module dmem_ram
#(
    parameter int mem_words = 1024
)
(
    input  logic clk_i
    , input  logic rst_n_i
    , input  logic req_i
    , input  logic we_i
    , input  logic [kerygma_pkg::addr_w-1:0] addr_i
    , input  logic [kerygma_pkg::be_w-1:0]   be_i
    , input  logic [kerygma_pkg::data_w-1:0] wdata_i
    , output logic ack_o
    , output logic resp_o
    , output logic [kerygma_pkg::data_w-1:0] rdata_o
);

    import kerygma_pkg::*;

    localparam int idx_w  = $clog2(mem_words);
    localparam int ofs_w  = $clog2(be_w);
    localparam int byte_w = data_w / be_w;

    logic [data_w-1:0] mem [mem_words];
    logic [idx_w-1:0] word_idx;

    // word index wraps modulo the array size
    assign word_idx = idx_w'(addr_i[addr_w-1:ofs_w] % mem_words);

    // no wait states
    assign ack_o = req_i;

    always_ff @(posedge clk_i)
    begin
        if (req_i && we_i)
            for (int i = 0; i < be_w; i++)
                if (be_i[i])
                    mem[word_idx][byte_w*i +: byte_w] <= wdata_i[byte_w*i +: byte_w];
        if (req_i && !we_i)
            rdata_o <= mem[word_idx];
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            resp_o <= 1'b0;
        else
            resp_o <= req_i && !we_i;
    end

    a_resp_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        resp_o |-> $past(ack_o && !we_i));

endmodule

// ==== logic/tile_sfr.sv ====
`timescale 1ns/1ps

module tile_sfr
#(
    parameter int corenum = 0
    , parameter int irq_num_pow = 4
)
(
    input  logic clk_i
    , input  logic rst_n_i
    , input  logic req_i
    , input  logic we_i
    , input  logic [kerygma_pkg::addr_w-1:0] addr_i
    , input  logic [kerygma_pkg::be_w-1:0]   be_i
    , input  logic [kerygma_pkg::data_w-1:0] wdata_i
    , output logic ack_o
    , output logic resp_o
    , output logic [kerygma_pkg::data_w-1:0] rdata_o
    , input  logic sw_reset_enb_i
    , input  logic sw_reset_set_i
    , input  logic sw_reset_autoclr_i
    , output logic core_reset_o
    , output logic [(2**irq_num_pow)-1:0] irq_en_o
    , output logic irq_timer_o
    , output logic sgi_req_o
    , output logic [irq_num_pow-1:0] sgi_code_o
);

    import kerygma_pkg::*;

    localparam int irq_num = 2**irq_num_pow;

    logic sw_rst_q, wr_en, rd_en;
    logic [sfr_bitsel-1:0] ofs;
    logic [data_w-1:0] period_q, count_q, rd_val;

    function automatic logic [data_w-1:0] be_merge(input logic [data_w-1:0] old_v,
                                                   input logic [data_w-1:0] new_v,
                                                   input logic [be_w-1:0] be);
        logic [data_w-1:0] res;
        res = old_v;
        for (int i = 0; i < be_w; i++)
            if (be[i])
                res[8*i +: 8] = new_v[8*i +: 8];
        return res;
    endfunction

    assign ofs          = addr_i[sfr_bitsel-1:0];
    assign wr_en        = req_i && we_i;
    assign rd_en        = req_i && !we_i;
    assign ack_o        = req_i;
    assign core_reset_o = !rst_n_i || sw_rst_q;

    always_comb
    begin
        rd_val = '0;
        case (ofs)
            sfr_id_ofs:     rd_val = data_w'(corenum);
            sfr_ctrl_ofs:   rd_val[0] = sw_rst_q;
            sfr_irq_en_ofs: rd_val[irq_num-1:0] = irq_en_o;
            sfr_timer_ofs:  rd_val = period_q;
            default:        rd_val = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            sw_rst_q    <= 1'b0;
            irq_en_o    <= '0;
            period_q    <= '0;
            count_q     <= '0;
            irq_timer_o <= 1'b0;
            sgi_req_o   <= 1'b0;
            resp_o      <= 1'b0;
        end
        else
        begin
            resp_o    <= rd_en;
            sgi_req_o <= wr_en && (ofs == sfr_sgi_ofs);
            // external set wins, autoclear drops the bit a cycle later
            if (sw_reset_enb_i && sw_reset_set_i)
                sw_rst_q <= 1'b1;
            else if (wr_en && (ofs == sfr_ctrl_ofs) && be_i[0])
                sw_rst_q <= wdata_i[0];
            else if (sw_reset_autoclr_i)
                sw_rst_q <= 1'b0;
            if (wr_en && (ofs == sfr_irq_en_ofs))
                irq_en_o <= irq_num'(be_merge(data_w'(irq_en_o), wdata_i, be_i));
            if (wr_en && (ofs == sfr_timer_ofs))
                period_q <= be_merge(period_q, wdata_i, be_i);
            // period of zero stops the timer
            if (period_q == '0)
            begin
                count_q     <= '0;
                irq_timer_o <= 1'b0;
            end
            else if (count_q >= period_q - 1'b1)
            begin
                count_q     <= '0;
                irq_timer_o <= 1'b1;
            end
            else
            begin
                count_q     <= count_q + 1'b1;
                irq_timer_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rd_en)
            rdata_o <= rd_val;
        if (wr_en && (ofs == sfr_sgi_ofs))
            sgi_code_o <= wdata_i[irq_num_pow-1:0];
    end

    a_sgi_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sgi_req_o |=> !sgi_req_o);

endmodule

// ==== logic/irq_adapter.sv ====
`timescale 1ns/1ps

module irq_adapter
#(
    parameter int irq_num_pow = 4
)
(
    input  logic clk_i
    , input  logic rst_n_i
    , input  logic [(2**irq_num_pow)-1:0] irq_lines_i
    , input  logic [(2**irq_num_pow)-1:0] irq_en_i
    , input  logic irq_timer_i
    , input  logic sgi_req_i
    , input  logic [irq_num_pow-1:0] sgi_code_i
    , output logic irq_req_o
    , output logic [irq_num_pow-1:0] irq_code_o
    , input  logic irq_ack_i
);

    localparam int irq_num = 2**irq_num_pow;

    logic [irq_num-1:0] lines_m, lines_q, pend_q, pend_set, pend_clr;
    logic [irq_num_pow-1:0] low_idx;

    // timer shares line 1
    assign lines_m  = (irq_lines_i | (irq_num'(irq_timer_i) << 1)) & irq_en_i;
    assign pend_clr = (irq_req_o && irq_ack_i) ? (irq_num'(1) << irq_code_o) : '0;

    always_comb
    begin
        pend_set = lines_m & ~lines_q;
        if (sgi_req_i)
            pend_set[sgi_code_i] = 1'b1;
    end

    // lowest pending index wins
    always_comb
    begin
        low_idx = '0;
        for (int i = irq_num - 1; i >= 0; i--)
            if (pend_q[i])
                low_idx = irq_num_pow'(i);
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            lines_q    <= '0;
            pend_q     <= '0;
            irq_req_o  <= 1'b0;
            irq_code_o <= '0;
        end
        else
        begin
            lines_q <= lines_m;
            pend_q  <= (pend_q & ~pend_clr) | pend_set;
            if (irq_req_o)
            begin
                if (irq_ack_i)
                    irq_req_o <= 1'b0;
            end
            else if (|pend_q)
            begin
                irq_req_o  <= 1'b1;
                irq_code_o <= low_idx;
            end
        end
    end

    a_code_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_req_o |=> !irq_req_o || $stable(irq_code_o));

endmodule

// ==== logic/kerygma_tile.sv ====
`timescale 1ns/1ps

module kerygma_tile
#(
    parameter int corenum = 0
    , parameter int mem_words = 1024
    , parameter int irq_num_pow = 4
)
(
    input  logic clk_i
    , input  logic rst_n_i

    , input  logic sw_reset_enb_i
    , input  logic sw_reset_set_i
    , input  logic sw_reset_autoclr_i
    , output logic core_reset_o

    , input  logic [(2**irq_num_pow)-1:0] irq_lines_i

    , input  logic host_req_i
    , input  logic host_we_i
    , input  logic [kerygma_pkg::addr_w-1:0] host_addr_i
    , input  logic [kerygma_pkg::be_w-1:0]   host_be_i
    , input  logic [kerygma_pkg::data_w-1:0] host_wdata_i
    , output logic host_ack_o
    , output logic host_resp_o
    , output logic [kerygma_pkg::data_w-1:0] host_rdata_o

    , input  logic core_req_i
    , input  logic core_we_i
    , input  logic [kerygma_pkg::addr_w-1:0] core_addr_i
    , input  logic [kerygma_pkg::be_w-1:0]   core_be_i
    , input  logic [kerygma_pkg::data_w-1:0] core_wdata_i
    , output logic core_ack_o
    , output logic core_resp_o
    , output logic [kerygma_pkg::data_w-1:0] core_rdata_o

    , output logic xif_req_o
    , output logic xif_we_o
    , output logic [kerygma_pkg::addr_w-1:0] xif_addr_o
    , output logic [kerygma_pkg::be_w-1:0]   xif_be_o
    , output logic [kerygma_pkg::data_w-1:0] xif_wdata_o
    , input  logic xif_ack_i
    , input  logic xif_resp_i
    , input  logic [kerygma_pkg::data_w-1:0] xif_rdata_i

    , output logic irq_req_o
    , output logic [irq_num_pow-1:0] irq_code_o
    , input  logic irq_ack_i
);

    import kerygma_pkg::*;

    logic dmem_req, dmem_we, dmem_ack, dmem_resp;
    logic sfr_req, sfr_we, sfr_ack, sfr_resp;
    logic [addr_w-1:0] dmem_addr, sfr_addr;
    logic [be_w-1:0] dmem_be, sfr_be;
    logic [data_w-1:0] dmem_wdata, dmem_rdata, sfr_wdata, sfr_rdata;
    logic [(2**irq_num_pow)-1:0] irq_en;
    logic irq_timer, sgi_req;
    logic [irq_num_pow-1:0] sgi_code;

    bus_arb_2m3s i_arb (
        .clk_i(clk_i), .rst_n_i(rst_n_i)
        , .m0_req_i(host_req_i), .m0_we_i(host_we_i), .m0_addr_i(host_addr_i)
        , .m0_be_i(host_be_i), .m0_wdata_i(host_wdata_i), .m0_ack_o(host_ack_o)
        , .m0_resp_o(host_resp_o), .m0_rdata_o(host_rdata_o)
        , .m1_req_i(core_req_i), .m1_we_i(core_we_i), .m1_addr_i(core_addr_i)
        , .m1_be_i(core_be_i), .m1_wdata_i(core_wdata_i), .m1_ack_o(core_ack_o)
        , .m1_resp_o(core_resp_o), .m1_rdata_o(core_rdata_o)
        , .s0_req_o(dmem_req), .s0_we_o(dmem_we), .s0_addr_o(dmem_addr)
        , .s0_be_o(dmem_be), .s0_wdata_o(dmem_wdata), .s0_ack_i(dmem_ack)
        , .s0_resp_i(dmem_resp), .s0_rdata_i(dmem_rdata)
        , .s1_req_o(sfr_req), .s1_we_o(sfr_we), .s1_addr_o(sfr_addr)
        , .s1_be_o(sfr_be), .s1_wdata_o(sfr_wdata), .s1_ack_i(sfr_ack)
        , .s1_resp_i(sfr_resp), .s1_rdata_i(sfr_rdata)
        , .s2_req_o(xif_req_o), .s2_we_o(xif_we_o), .s2_addr_o(xif_addr_o)
        , .s2_be_o(xif_be_o), .s2_wdata_o(xif_wdata_o), .s2_ack_i(xif_ack_i)
        , .s2_resp_i(xif_resp_i), .s2_rdata_i(xif_rdata_i)
    );

    dmem_ram #(.mem_words(mem_words)) i_dmem (
        .clk_i(clk_i), .rst_n_i(rst_n_i)
        , .req_i(dmem_req), .we_i(dmem_we), .addr_i(dmem_addr), .be_i(dmem_be)
        , .wdata_i(dmem_wdata), .ack_o(dmem_ack), .resp_o(dmem_resp), .rdata_o(dmem_rdata)
    );

    tile_sfr #(.corenum(corenum), .irq_num_pow(irq_num_pow)) i_sfr (
        .clk_i(clk_i), .rst_n_i(rst_n_i)
        , .req_i(sfr_req), .we_i(sfr_we), .addr_i(sfr_addr), .be_i(sfr_be)
        , .wdata_i(sfr_wdata), .ack_o(sfr_ack), .resp_o(sfr_resp), .rdata_o(sfr_rdata)
        , .sw_reset_enb_i(sw_reset_enb_i), .sw_reset_set_i(sw_reset_set_i)
        , .sw_reset_autoclr_i(sw_reset_autoclr_i), .core_reset_o(core_reset_o)
        , .irq_en_o(irq_en), .irq_timer_o(irq_timer)
        , .sgi_req_o(sgi_req), .sgi_code_o(sgi_code)
    );

    // interrupt state follows the core reset
    irq_adapter #(.irq_num_pow(irq_num_pow)) i_irq (
        .clk_i(clk_i), .rst_n_i(!core_reset_o)
        , .irq_lines_i(irq_lines_i), .irq_en_i(irq_en), .irq_timer_i(irq_timer)
        , .sgi_req_i(sgi_req), .sgi_code_i(sgi_code)
        , .irq_req_o(irq_req_o), .irq_code_o(irq_code_o), .irq_ack_i(irq_ack_i)
    );

endmodule

// ==== sim/kerygma_tile_tb.sv ====
`timescale 1ns/1ps

module kerygma_tile_tb;

    import kerygma_pkg::*;

    localparam int corenum = 3;
    localparam int mem_words = 64;
    localparam int irq_num_pow = 4;
    localparam int irq_num = 2**irq_num_pow;
    localparam logic [addr_w-1:0] sfr_base = addr_w'(1) << sfr_bitsel;

    logic clk_i, rst_n_i;
    logic sw_reset_enb_i, sw_reset_set_i, sw_reset_autoclr_i, core_reset_o;
    logic [irq_num-1:0] irq_lines_i;
    logic host_req_i, host_we_i, host_ack_o, host_resp_o;
    logic [addr_w-1:0] host_addr_i;
    logic [be_w-1:0] host_be_i;
    logic [data_w-1:0] host_wdata_i, host_rdata_o;
    logic core_req_i, core_we_i, core_ack_o, core_resp_o;
    logic [addr_w-1:0] core_addr_i;
    logic [be_w-1:0] core_be_i;
    logic [data_w-1:0] core_wdata_i, core_rdata_o;
    logic xif_req_o, xif_we_o, xif_ack_i, xif_resp_i;
    logic [addr_w-1:0] xif_addr_o;
    logic [be_w-1:0] xif_be_o;
    logic [data_w-1:0] xif_wdata_o, xif_rdata_i;
    logic irq_req_o, irq_ack_i;
    logic [irq_num_pow-1:0] irq_code_o;

    integer seed = 32'h1564a7e9;
    int errors = 0;
    int checks = 0;
    int cyc = 0;
    int ack_cyc [2];
    bit last_gnt = 1'b1;
    logic [data_w-1:0] ram_model [mem_words];

    // expansion responder state
    bit xif_seen;
    logic xif_we_seen;
    logic [addr_w-1:0] xif_addr_seen;
    logic [be_w-1:0] xif_be_seen;
    logic [data_w-1:0] xif_wdata_seen;
    int xif_delay;

    kerygma_tile #(.corenum(corenum), .mem_words(mem_words), .irq_num_pow(irq_num_pow)) i_dut (
        .clk_i(clk_i), .rst_n_i(rst_n_i)
        , .sw_reset_enb_i(sw_reset_enb_i), .sw_reset_set_i(sw_reset_set_i)
        , .sw_reset_autoclr_i(sw_reset_autoclr_i), .core_reset_o(core_reset_o)
        , .irq_lines_i(irq_lines_i)
        , .host_req_i(host_req_i), .host_we_i(host_we_i), .host_addr_i(host_addr_i)
        , .host_be_i(host_be_i), .host_wdata_i(host_wdata_i), .host_ack_o(host_ack_o)
        , .host_resp_o(host_resp_o), .host_rdata_o(host_rdata_o)
        , .core_req_i(core_req_i), .core_we_i(core_we_i), .core_addr_i(core_addr_i)
        , .core_be_i(core_be_i), .core_wdata_i(core_wdata_i), .core_ack_o(core_ack_o)
        , .core_resp_o(core_resp_o), .core_rdata_o(core_rdata_o)
        , .xif_req_o(xif_req_o), .xif_we_o(xif_we_o), .xif_addr_o(xif_addr_o)
        , .xif_be_o(xif_be_o), .xif_wdata_o(xif_wdata_o), .xif_ack_i(xif_ack_i)
        , .xif_resp_i(xif_resp_i), .xif_rdata_i(xif_rdata_i)
        , .irq_req_o(irq_req_o), .irq_code_o(irq_code_o), .irq_ack_i(irq_ack_i)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i)
        cyc <= cyc + 1;

    function automatic logic [data_w-1:0] ram_fill(input int idx);
        return data_w'(idx) * 32'h9e37_79b9 ^ 32'h1234_5678;
    endfunction

    function automatic logic [data_w-1:0] xif_reply(input logic [addr_w-1:0] addr);
        return {addr[15:0], ~addr[31:16]} ^ 32'hc3a5_1e0f;
    endfunction

    task automatic check_data(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_irq_code(input string name, input logic [irq_num_pow-1:0] got,
                                  input logic [irq_num_pow-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic drive_cmd(input bit m, input logic req, input logic we,
                             input logic [addr_w-1:0] addr, input logic [be_w-1:0] be,
                             input logic [data_w-1:0] wdata);
        if (m)
            {core_req_i, core_we_i, core_addr_i, core_be_i, core_wdata_i} =
                {req, we, addr, be, wdata};
        else
            {host_req_i, host_we_i, host_addr_i, host_be_i, host_wdata_i} =
                {req, we, addr, be, wdata};
    endtask

    // one transfer from master m (0 host, 1 core), lat counts cycles from req
    task automatic bus_access(input bit m, input logic we, input logic [addr_w-1:0] addr,
                              input logic [be_w-1:0] be, input logic [data_w-1:0] wdata,
                              output logic [data_w-1:0] rdata, output int lat);
        bit got;
        got = 1'b0;
        lat = 0;
        rdata = '0;
        @(posedge clk_i);
        #1;
        drive_cmd(m, 1'b1, we, addr, be, wdata);
        while (!got && lat < 100)
        begin
            @(negedge clk_i);
            lat++;
            got = m ? core_ack_o : host_ack_o;
        end
        if (!got)
        begin
            errors++;
            $display("master %0d never got an ack for address %h", m, addr);
        end
        else
        begin
            last_gnt = m;
            ack_cyc[m] = cyc;
        end
        @(posedge clk_i);
        #1;
        drive_cmd(m, 1'b0, 1'b0, '0, '0, '0);
        if (got && !we)
        begin
            got = 1'b0;
            while (!got && lat < 100)
            begin
                @(negedge clk_i);
                lat++;
                got = m ? core_resp_o : host_resp_o;
                rdata = m ? core_rdata_o : host_rdata_o;
            end
            if (!got)
            begin
                errors++;
                $display("master %0d never got read data for address %h", m, addr);
            end
        end
    endtask

    task automatic reg_write(input logic [sfr_bitsel-1:0] ofs, input logic [data_w-1:0] d);
        logic [data_w-1:0] rd;
        int lat;
        bus_access(1'b0, 1'b1, sfr_base | addr_w'(ofs), 4'hF, d, rd, lat);
    endtask

    task automatic reg_read(input logic [sfr_bitsel-1:0] ofs, output logic [data_w-1:0] rd);
        int lat;
        bus_access(1'b0, 1'b0, sfr_base | addr_w'(ofs), 4'hF, '0, rd, lat);
        check_data("register read latency", data_w'(lat), 32'd3);
    endtask

    task automatic wait_core_reset(input logic level, input int limit);
        int n;
        n = 0;
        while (core_reset_o !== level && n < limit)
        begin
            @(negedge clk_i);
            n++;
        end
        if (core_reset_o !== level)
        begin
            errors++;
            $display("core_reset_o did not reach %0d in time", level);
        end
    endtask

    // wait for an offer, check its code, then acknowledge it
    task automatic irq_expect(input logic [irq_num_pow-1:0] code, input int limit);
        int n;
        n = 0;
        while (!irq_req_o && n < limit)
        begin
            @(negedge clk_i);
            n++;
        end
        if (!irq_req_o)
        begin
            errors++;
            $display("no interrupt request arrived for code %0d", code);
        end
        else
        begin
            check_irq_code("irq_code_o", irq_code_o, code);
            @(posedge clk_i);
            #1;
            irq_ack_i = 1'b1;
            @(posedge clk_i);
            #1;
            irq_ack_i = 1'b0;
            @(negedge clk_i);
            check_bit("irq_req_o after ack", irq_req_o, 1'b0);
        end
    endtask

    task automatic set_lines(input logic [irq_num-1:0] v);
        @(posedge clk_i);
        #1;
        irq_lines_i = v;
    endtask

    // expansion target with random ack and resp delays
    always
    begin
        @(negedge clk_i);
        if (xif_req_o)
        begin
            xif_seen = 1'b1;
            {xif_we_seen, xif_addr_seen, xif_be_seen, xif_wdata_seen} =
                {xif_we_o, xif_addr_o, xif_be_o, xif_wdata_o};
            xif_delay = $unsigned($random(seed)) % 4;
            repeat (xif_delay)
            begin
                @(posedge clk_i);
                #1;
            end
            @(posedge clk_i);
            #1;
            xif_ack_i = 1'b1;
            @(posedge clk_i);
            #1;
            xif_ack_i = 1'b0;
            if (!xif_we_seen)
            begin
                xif_delay = $unsigned($random(seed)) % 4;
                repeat (xif_delay)
                begin
                    @(posedge clk_i);
                    #1;
                end
                xif_resp_i = 1'b1;
                xif_rdata_i = xif_reply(xif_addr_seen);
                @(posedge clk_i);
                #1;
                xif_resp_i = 1'b0;
            end
        end
    end

    initial
    begin
        logic [addr_w-1:0] addr, a0, a1;
        logic [be_w-1:0] be;
        logic [data_w-1:0] wdata, rd, rd0, rd1, exp0, exp1;
        logic we;
        bit m, exp_win;
        int lat, lat0, lat1, idx;

        clk_i = 1'b0;
        rst_n_i = 1'b0;
        {sw_reset_enb_i, sw_reset_set_i, sw_reset_autoclr_i} = 3'b000;
        irq_lines_i = '0;
        irq_ack_i = 1'b0;
        drive_cmd(1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_cmd(1'b1, 1'b0, 1'b0, '0, '0, '0);
        {xif_ack_i, xif_resp_i, xif_rdata_i} = '0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_bit("core_reset_o after reset", core_reset_o, 1'b0);
        check_bit("irq_req_o after reset", irq_req_o, 1'b0);
        // idle grant means the first write is acked one cycle after req
        bus_access(1'b0, 1'b1, '0, 4'hF, ram_fill(0), rd, lat);
        check_data("write ack latency after reset", data_w'(lat), 32'd2);

        for (int i = 0; i < mem_words; i++)
        begin
            bus_access(1'b0, 1'b1, addr_w'(i) << 2, 4'hF, ram_fill(i), rd, lat);
            ram_model[i] = ram_fill(i);
        end

        // random RAM traffic, addresses wrap past mem_words
        for (int k = 0; k < 200; k++)
        begin
            m = 1'($random(seed));
            we = 1'($random(seed));
            addr = addr_w'($random(seed)) & 32'h7FEF_FFFF;
            be = be_w'($random(seed));
            wdata = data_w'($random(seed));
            idx = int'((addr >> 2) % mem_words);
            bus_access(m, we, addr, be, wdata, rd, lat);
            if (we)
            begin
                for (int b = 0; b < be_w; b++)
                    if (be[b])
                        ram_model[idx][8*b +: 8] = wdata[8*b +: 8];
            end
            else
            begin
                check_data("RAM rdata", rd, ram_model[idx]);
                check_data("RAM read latency", data_w'(lat), 32'd3);
            end
        end

        // simultaneous requests from both masters
        for (int k = 0; k < 8; k++)
        begin
            exp_win = !last_gnt;
            a0 = addr_w'($random(seed)) & 32'h000F_FFFC;
            a1 = addr_w'($random(seed)) & 32'h000F_FFFC;
            exp0 = ram_model[int'((a0 >> 2) % mem_words)];
            exp1 = ram_model[int'((a1 >> 2) % mem_words)];
            if (k % 2 == 1)
            begin
                a1 = sfr_base | addr_w'(sfr_id_ofs);
                exp1 = data_w'(corenum);
            end
            fork
                bus_access(1'b0, 1'b0, a0, 4'hF, '0, rd0, lat0);
                bus_access(1'b1, 1'b0, a1, 4'hF, '0, rd1, lat1);
            join
            check_data("host_rdata_o on tie", rd0, exp0);
            check_data("core_rdata_o on tie", rd1, exp1);
            check_bit("core wins tie", ack_cyc[1] < ack_cyc[0], exp_win);
            check_data("tie winner read latency", data_w'(exp_win ? lat1 : lat0), 32'd3);
        end

        for (int k = 0; k < 16; k++)
        begin
            m = 1'($random(seed));
            we = 1'($random(seed));
            addr = addr_w'($random(seed)) | 32'h8000_0000;
            be = be_w'($random(seed));
            wdata = data_w'($random(seed));
            xif_seen = 1'b0;
            bus_access(m, we, addr, be, wdata, rd, lat);
            check_bit("xif request seen", xif_seen, 1'b1);
            check_bit("xif_we_o", xif_we_seen, we);
            check_data("xif_addr_o", xif_addr_seen, addr);
            check_data("xif_be_o", data_w'(xif_be_seen), data_w'(be));
            check_data("xif_wdata_o", xif_wdata_seen, wdata);
            if (!we)
                check_data("xif read data", rd, xif_reply(addr));
        end

        reg_read(sfr_id_ofs, rd);
        check_data("id register", rd, data_w'(corenum));
        wdata = data_w'($random(seed));
        reg_write(sfr_irq_en_ofs, wdata);
        reg_read(sfr_irq_en_ofs, rd);
        check_data("irq enable register", rd, wdata & 32'h0000_FFFF);
        // top bit set keeps the timer from firing here
        wdata = data_w'($random(seed)) | 32'h8000_0000;
        reg_write(sfr_timer_ofs, wdata);
        reg_read(sfr_timer_ofs, rd);
        check_data("timer period register", rd, wdata);
        reg_write(sfr_timer_ofs, '0);

        @(posedge clk_i);
        #1;
        {sw_reset_enb_i, sw_reset_set_i} = 2'b11;
        @(posedge clk_i);
        #1;
        {sw_reset_enb_i, sw_reset_set_i} = 2'b00;
        @(negedge clk_i);
        check_bit("core_reset_o after set", core_reset_o, 1'b1);
        reg_read(sfr_ctrl_ofs, rd);
        check_data("ctrl register", rd, 32'h1);
        reg_write(sfr_ctrl_ofs, '0);
        @(negedge clk_i);
        check_bit("core_reset_o after clear", core_reset_o, 1'b0);
        sw_reset_autoclr_i = 1'b1;
        @(posedge clk_i);
        #1;
        {sw_reset_enb_i, sw_reset_set_i} = 2'b11;
        @(posedge clk_i);
        #1;
        {sw_reset_enb_i, sw_reset_set_i} = 2'b00;
        wait_core_reset(1'b1, 4);
        wait_core_reset(1'b0, 4);
        sw_reset_autoclr_i = 1'b0;

        // lines 1, 2, 3 and 5 enabled
        reg_write(sfr_irq_en_ofs, 32'h0000_002E);
        set_lines(irq_num'(1) << 4);
        for (int n = 0; n < 8; n++)
        begin
            @(negedge clk_i);
            check_bit("irq_req_o for disabled line", irq_req_o, 1'b0);
        end
        set_lines('0);
        set_lines(irq_num'(1) << 3);
        irq_expect(4'd3, 10);
        set_lines('0);
        set_lines((irq_num'(1) << 5) | (irq_num'(1) << 3) | (irq_num'(1) << 2));
        irq_expect(4'd2, 10);
        irq_expect(4'd3, 10);
        irq_expect(4'd5, 10);
        set_lines('0);

        reg_write(sfr_sgi_ofs, 32'd9);
        irq_expect(4'd9, 10);
        reg_write(sfr_timer_ofs, 32'd20);
        irq_expect(4'd1, 40);
        reg_write(sfr_timer_ofs, '0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== kerygma_tile.f ====
logic/kerygma_pkg.sv
logic/bus_arb_2m3s.sv
logic/dmem_ram.sv
logic/tile_sfr.sv
logic/irq_adapter.sv
logic/kerygma_tile.sv
sim/kerygma_tile_tb.sv

// ==== Makefile ====
TOP := kerygma_tile_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f kerygma_tile.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
